// ==== common/mac_bridge_cfg.svh ====
`ifndef MAC_BRIDGE_CFG_SVH
`define MAC_BRIDGE_CFG_SVH

//**************************************************************************
// bridge sizing
//**************************************************************************

// word width on both the stream and the MAC user side
`define MAC_DATA_W 32

// fifo address bits, depth is 2**MAC_FIFO_AW words
`define MAC_FIFO_AW 4

// rx fill level where the MAC read level is pulled low
// depth minus this value is the slack for words still in flight
`define RX_FILL_LIMIT 10

`endif

// ==== common/mac_bridge_pkg.sv ====
`include "mac_bridge_cfg.svh"

package mac_bridge_pkg;

	// bytes per word on the stream side
	localparam int AXIS_KEEP_W = `MAC_DATA_W / 8;

	//**************************************************************************
	// MAC byte-enable code
	//**************************************************************************

	// number of valid bytes in the last word of a frame
	typedef logic [1:0] mac_be_t;

	localparam mac_be_t BE_FOUR  = 2'b00;
	localparam mac_be_t BE_THREE = 2'b11;
	localparam mac_be_t BE_TWO   = 2'b10;
	localparam mac_be_t BE_ONE   = 2'b01;

	//**************************************************************************
	// word and beat formats
	//**************************************************************************

	// fifo entry, same layout as the MAC user word
	typedef struct packed {
		logic                   sop;
		logic                   eop;
		mac_be_t                be;
		logic [`MAC_DATA_W-1:0] data;
	} mac_word_t;

	// valid/ready stream beat, keep msb is the first byte
	typedef struct packed {
		logic [`MAC_DATA_W-1:0] data;
		logic [AXIS_KEEP_W-1:0] keep;
		logic                   last;
	} axis_beat_t;

endpackage

// ==== compile.f ====
+incdir+common
common/mac_bridge_pkg.sv
logic/word_fifo.sv
logic/stream_codec.sv
logic/rx_read_ctrl.sv
logic/mac_stream_bridge.sv
tb/tb_mac_stream_bridge.sv

// ==== logic/mac_stream_bridge.sv ====
`timescale 1ns/1ps

`include "mac_bridge_cfg.svh"

module mac_stream_bridge (
	input  logic                       Clk_user,
	input  logic                       Rst_user,
	// transmit stream in
	input  mac_bridge_pkg::axis_beat_t tx_beat,
	input  logic                       tx_valid,
	output logic                       tx_ready,
	// MAC transmit user side
	input  logic                       mac_tx_wa,
	output mac_bridge_pkg::mac_word_t  mac_tx_word,
	output logic                       mac_tx_wr,
	// MAC receive user side
	input  logic                       mac_rx_ra,
	input  logic                       mac_rx_pa,
	input  mac_bridge_pkg::mac_word_t  mac_rx_word,
	output logic                       mac_rx_rd,
	// receive stream out
	output mac_bridge_pkg::axis_beat_t rx_beat,
	output logic                       rx_valid,
	input  logic                       rx_ready
);
	import mac_bridge_pkg::*;

	mac_word_t             tx_enc_word;
	mac_word_t             rx_fifo_word;
	logic                  tx_fifo_full;
	logic                  tx_fifo_empty;
	logic                  rx_fifo_empty;
	logic [`MAC_FIFO_AW:0] rx_fifo_fill;

	// handshakes straight off the fifo flags
	assign tx_ready  = !tx_fifo_full;
	assign mac_tx_wr = !tx_fifo_empty && mac_tx_wa;
	assign rx_valid  = !rx_fifo_empty;

	//**************************************************************************
	// transmit path
	//**************************************************************************

	// words stored already encoded for the MAC
	word_fifo tx_fifo_i (
		.Clk_user (Clk_user),
		.Rst_user (Rst_user),
		.wr_en    (tx_valid && tx_ready),
		.wr_word  (tx_enc_word),
		.rd_en    (mac_tx_wr),
		.rd_word  (mac_tx_word),
		.empty    (tx_fifo_empty),
		.full     (tx_fifo_full),
		.fill     ()
	);

	// both directions of beat/word conversion
	stream_codec codec_i (
		.Clk_user (Clk_user),
		.Rst_user (Rst_user),
		.tx_beat  (tx_beat),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.tx_word  (tx_enc_word),
		.rx_word  (rx_fifo_word),
		.rx_beat  (rx_beat)
	);

	//**************************************************************************
	// receive path
	//**************************************************************************

	// every pa strobe lands here, full is covered by the read throttle
	word_fifo rx_fifo_i (
		.Clk_user (Clk_user),
		.Rst_user (Rst_user),
		.wr_en    (mac_rx_pa),
		.wr_word  (mac_rx_word),
		.rd_en    (rx_valid && rx_ready),
		.rd_word  (rx_fifo_word),
		.empty    (rx_fifo_empty),
		.full     (),
		.fill     (rx_fifo_fill)
	);

	// paces the MAC read level from the rx fill
	rx_read_ctrl rx_ctrl_i (
		.Clk_user   (Clk_user),
		.Rst_user   (Rst_user),
		.mac_rx_ra  (mac_rx_ra),
		.mac_rx_pa  (mac_rx_pa),
		.mac_rx_eop (mac_rx_word.eop),
		.fill       (rx_fifo_fill),
		.mac_rx_rd  (mac_rx_rd)
	);

endmodule

// ==== logic/rx_read_ctrl.sv ====
`timescale 1ns/1ps

`include "mac_bridge_cfg.svh"

module rx_read_ctrl (
	input  logic                  Clk_user,
	input  logic                  Rst_user,
	input  logic                  mac_rx_ra,
	input  logic                  mac_rx_pa,
	input  logic                  mac_rx_eop,
	input  logic [`MAC_FIFO_AW:0] fill,
	output logic                  mac_rx_rd
);

	localparam logic [`MAC_FIFO_AW:0] FILL_LIMIT = `RX_FILL_LIMIT;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_READ,
		RD_GAP
	} rd_state_t;

	rd_state_t state;
	logic      below_limit;

	// room left in the rx fifo for another burst
	assign below_limit = (fill < FILL_LIMIT);

	//**************************************************************************
	// read level FSM
	//**************************************************************************

	always_ff @(posedge Clk_user or posedge Rst_user) begin
		if (Rst_user) begin
			state     <= RD_IDLE;
			mac_rx_rd <= 1'b0;
		end else begin
			case (state)
				// wait for the MAC to have data
				RD_IDLE: begin
					if (mac_rx_ra) begin
						mac_rx_rd <= below_limit;
						state     <= RD_READ;
					end
				end
				// follow fill level until the frame ends
				RD_READ: begin
					if (mac_rx_pa && mac_rx_eop) begin
						mac_rx_rd <= 1'b0;
						state     <= RD_GAP;
					end else begin
						mac_rx_rd <= below_limit;
					end
				end
				// one idle cycle between frames
				RD_GAP: begin
					state <= RD_IDLE;
				end
				default: begin
					state     <= RD_IDLE;
					mac_rx_rd <= 1'b0;
				end
			endcase
		end
	end

	// throttle margin must cover words still coming from the MAC
	a_no_overflow: assert property (
		@(posedge Clk_user) disable iff (Rst_user) mac_rx_pa |-> !fill[`MAC_FIFO_AW]
	) else $error("rx_read_ctrl: MAC word into full rx fifo");

endmodule

// ==== logic/stream_codec.sv ====
`timescale 1ns/1ps

`include "mac_bridge_cfg.svh"

module stream_codec (
	input  logic                       Clk_user,
	input  logic                       Rst_user,
	input  mac_bridge_pkg::axis_beat_t tx_beat,
	input  logic                       tx_valid,
	input  logic                       tx_ready,
	output mac_bridge_pkg::mac_word_t  tx_word,
	input  mac_bridge_pkg::mac_word_t  rx_word,
	output mac_bridge_pkg::axis_beat_t rx_beat
);
	import mac_bridge_pkg::*;

	// high between first and last beat of a tx frame
	logic                   frame_open;
	mac_be_t                tx_be;
	logic [AXIS_KEEP_W-1:0] rx_keep;

	//**************************************************************************
	// transmit, stream beat to MAC word
	//**************************************************************************

	// only accepted beats move the frame tracking
	// last closes the frame, so a one-word frame leaves it clear
	always_ff @(posedge Clk_user or posedge Rst_user) begin
		if (Rst_user) begin
			frame_open <= 1'b0;
		end else if (tx_valid && tx_ready) begin
			frame_open <= !tx_beat.last;
		end
	end

	// keep is left aligned, count leading ones
	always_comb begin
		casez (tx_beat.keep)
			4'b1110: tx_be = BE_THREE;
			4'b110?: tx_be = BE_TWO;
			4'b10??: tx_be = BE_ONE;
			default: tx_be = BE_FOUR;
		endcase
	end

	// sop marks the first word after a closed frame
	assign tx_word = '{
		sop:  !frame_open,
		eop:  tx_beat.last,
		be:   tx_be,
		data: tx_beat.data
	};

	//**************************************************************************
	// receive, MAC word to stream beat
	//**************************************************************************

	// code back to left aligned keep
	always_comb begin
		unique case (rx_word.be)
			BE_FOUR:  rx_keep = 4'b1111;
			BE_THREE: rx_keep = 4'b1110;
			BE_TWO:   rx_keep = 4'b1100;
			BE_ONE:   rx_keep = 4'b1000;
		endcase
	end

	// sop has no place on the stream, eop becomes last
	assign rx_beat = '{
		data: rx_word.data,
		keep: rx_keep,
		last: rx_word.eop
	};

endmodule

// ==== logic/word_fifo.sv ====
`timescale 1ns/1ps

`include "mac_bridge_cfg.svh"

module word_fifo #(
	parameter int ADDR_W = `MAC_FIFO_AW
) (
	input  logic                      Clk_user,
	input  logic                      Rst_user,
	input  logic                      wr_en,
	input  mac_bridge_pkg::mac_word_t wr_word,
	input  logic                      rd_en,
	output mac_bridge_pkg::mac_word_t rd_word,
	output logic                      empty,
	output logic                      full,
	output logic [ADDR_W:0]           fill
);
	import mac_bridge_pkg::*;

	localparam int DEPTH = 2 ** ADDR_W;

	// register array holding the words
	mac_word_t mem [DEPTH];

	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W:0]   count;
	logic              wr_ok;
	logic              rd_ok;

	// guard the pointers against misuse
	assign wr_ok = wr_en && !full;
	assign rd_ok = rd_en && !empty;

	// count never exceeds depth, so msb set means full
	assign empty = (count == '0);
	assign full  = count[ADDR_W];
	assign fill  = count;

	// first word falls through, head is always on the output
	assign rd_word = mem[rd_ptr];

	//**************************************************************************
	// write side
	//**************************************************************************

	always_ff @(posedge Clk_user) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wr_word;
		end
	end

	//**************************************************************************
	// pointers and fill count
	//**************************************************************************

	always_ff @(posedge Clk_user or posedge Rst_user) begin
		if (Rst_user) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap naturally at depth
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// push and pop together leave count alone
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// upstream must honour full and empty
	a_no_write_full: assert property (
		@(posedge Clk_user) disable iff (Rst_user) wr_en |-> !full
	) else $error("word_fifo: write while full");

	a_no_read_empty: assert property (
		@(posedge Clk_user) disable iff (Rst_user) rd_en |-> !empty
	) else $error("word_fifo: read while empty");

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f compile.f \
	--top-module tb_mac_stream_bridge \
	-o sim_mac_bridge

./obj_dir/sim_mac_bridge > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== tb/tb_mac_stream_bridge.sv ====
`timescale 1ns/1ps

`include "mac_bridge_cfg.svh"

module tb_mac_stream_bridge;
	import mac_bridge_pkg::*;

	localparam int FIFO_DEPTH = 2 ** `MAC_FIFO_AW;
	localparam int RX_LIMIT   = `RX_FILL_LIMIT;
	localparam int N_FRAMES   = 6;
	localparam int BP_LEN     = 20;
	localparam int THR_LEN    = 20;

	// keep and be columns describe the last word of a frame
	typedef struct packed {
		logic [7:0]  len;
		logic [3:0]  tx_keep;
		mac_be_t     be;
		logic [3:0]  rx_keep;
		logic [31:0] seed;
	} frame_t;

	// len, tx keep, expected be, expected rx keep, data seed
	localparam frame_t FRAMES [N_FRAMES] = '{
		'{8'd1,  4'b1111, 2'b00, 4'b1111, 32'h1000_0000},
		'{8'd3,  4'b1110, 2'b11, 4'b1110, 32'h2100_0000},
		'{8'd5,  4'b1100, 2'b10, 4'b1100, 32'h3200_0000},
		'{8'd2,  4'b1000, 2'b01, 4'b1000, 32'h4300_0000},
		'{8'd4,  4'b1101, 2'b10, 4'b1100, 32'h5400_0000},
		'{8'd14, 4'b1111, 2'b00, 4'b1111, 32'h6500_0000}
	};

	logic       Clk_user = 1'b0;
	logic       Rst_user;
	axis_beat_t tx_beat;
	logic       tx_valid;
	logic       tx_ready;
	logic       mac_tx_wa = 1'b0;
	mac_word_t  mac_tx_word;
	logic       mac_tx_wr;
	logic       mac_rx_ra = 1'b0;
	logic       mac_rx_pa = 1'b0;
	mac_word_t  mac_rx_word = '0;
	logic       mac_rx_rd;
	axis_beat_t rx_beat;
	logic       rx_valid;
	logic       rx_ready = 1'b0;

	// expected words and the MAC receive source
	mac_word_t   tx_exp [$];
	mac_word_t   rx_src [$];
	axis_beat_t  rx_exp [$];
	logic [31:0] rng = 32'h0644_5740;
	logic        wa_hold_low = 1'b0;
	logic        rx_hold_low = 1'b0;
	int          tx_accepts = 0;
	int          rx_written = 0;
	int          gap_left = 0;
	int          err_count = 0;
	int          check_count = 0;
	int          test_count = 0;
	int          test_err_base = 0;
	int          cycles = 0;
	int          cycle_limit = 100000;

	mac_stream_bridge dut_i (
		.Clk_user    (Clk_user),
		.Rst_user    (Rst_user),
		.tx_beat     (tx_beat),
		.tx_valid    (tx_valid),
		.tx_ready    (tx_ready),
		.mac_tx_wa   (mac_tx_wa),
		.mac_tx_word (mac_tx_word),
		.mac_tx_wr   (mac_tx_wr),
		.mac_rx_ra   (mac_rx_ra),
		.mac_rx_pa   (mac_rx_pa),
		.mac_rx_word (mac_rx_word),
		.mac_rx_rd   (mac_rx_rd),
		.rx_beat     (rx_beat),
		.rx_valid    (rx_valid),
		.rx_ready    (rx_ready)
	);

	// 10 ns period
	always #5 Clk_user = ~Clk_user;

	//**************************************************************************
	// helpers
	//**************************************************************************

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_word(input string name, input mac_word_t got, input mac_word_t exp);
		check_count = check_count + 1;
		if (got !== exp) begin
			err_count = err_count + 1;
			$display("ERR %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
		check_count = check_count + 1;
		if (got !== exp) begin
			err_count = err_count + 1;
			$display("ERR %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_count = check_count + 1;
		if (got !== exp) begin
			err_count = err_count + 1;
			$display("ERR %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic report_fail(input string msg);
		err_count = err_count + 1;
		$display("failure: %s", msg);
	endtask

	// one result line per test
	task automatic finish_test(input string name);
		test_count = test_count + 1;
		if (err_count == test_err_base) begin
			$display("test %0d %s: pass", test_count, name);
		end else begin
			$display("test %0d %s: fail, %0d errors", test_count, name,
				err_count - test_err_base);
		end
		test_err_base = err_count;
	endtask

	// drives one frame with each beat held until accepted
	task automatic send_frame(input int len, input logic [3:0] last_keep,
			input mac_be_t last_be, input logic [31:0] seed);
		axis_beat_t beat;
		mac_word_t  word;
		@(posedge Clk_user);
		#1;
		for (int i = 0; i < len; i++) begin
			beat.data = seed + 32'(i);
			beat.last = (i == len - 1);
			beat.keep = beat.last ? last_keep : 4'b1111;
			// sop on the first word only
			word.sop  = (i == 0);
			word.eop  = beat.last;
			word.be   = beat.last ? last_be : 2'b00;
			word.data = beat.data;
			tx_exp.push_back(word);
			tx_beat  = beat;
			tx_valid = 1'b1;
			@(negedge Clk_user);
			while (!tx_ready) begin
				@(negedge Clk_user);
			end
			@(posedge Clk_user);
			#1;
		end
		tx_valid = 1'b0;
	endtask

	// queues a frame at the MAC model and its expected stream beats
	task automatic load_rx_frame(input int len, input mac_be_t last_be,
			input logic [3:0] last_keep, input logic [31:0] seed);
		mac_word_t  word;
		axis_beat_t beat;
		for (int i = 0; i < len; i++) begin
			word.sop  = (i == 0);
			word.eop  = (i == len - 1);
			word.be   = word.eop ? last_be : 2'b00;
			word.data = seed + 32'(i);
			beat.data = word.data;
			beat.keep = word.eop ? last_keep : 4'b1111;
			beat.last = word.eop;
			rx_src.push_back(word);
			rx_exp.push_back(beat);
		end
	endtask

	task automatic wait_tx_drain();
		while (tx_exp.size() != 0) begin
			@(negedge Clk_user);
		end
	endtask

	task automatic wait_rx_drain();
		while (rx_exp.size() != 0 || rx_src.size() != 0) begin
			@(negedge Clk_user);
		end
	endtask

	//**************************************************************************
	// MAC model, stream sink and monitors
	//**************************************************************************

	// inputs change 1 ns after the edge
	always @(posedge Clk_user) begin
		#1;
		rng = xorshift32(rng);
		mac_tx_wa = !wa_hold_low && rng[0];
		rx_ready  = !rx_hold_low && rng[7];
		// pa only while the bridge holds rd high
		if (mac_rx_rd && rx_src.size() != 0) begin
			mac_rx_word = rx_src.pop_front();
			mac_rx_pa   = 1'b1;
		end else begin
			mac_rx_pa = 1'b0;
		end
		mac_rx_ra = (rx_src.size() != 0);
	end

	// transfers counted on the edge that takes them
	always @(posedge Clk_user) begin
		if (!Rst_user) begin
			if (tx_valid && tx_ready) begin
				tx_accepts = tx_accepts + 1;
			end
			if (mac_rx_pa) begin
				rx_written = rx_written + 1;
			end
		end
	end

	// outputs sampled mid cycle
	always @(negedge Clk_user) begin
		if (!Rst_user) begin
			if (mac_tx_wr) begin
				if (tx_exp.size() == 0) begin
					report_fail("mac_tx_wr high with no word pending");
				end else begin
					check_word("mac_tx_word", mac_tx_word, tx_exp.pop_front());
				end
			end
			if (rx_valid && rx_ready) begin
				if (rx_exp.size() == 0) begin
					report_fail("rx_valid high with no beat pending");
				end else begin
					check_beat("rx_beat", rx_beat, rx_exp.pop_front());
				end
			end
			// read level stays down across the frame gap
			if (gap_left > 0) begin
				check_bit("mac_rx_rd", mac_rx_rd, 1'b0);
				gap_left = gap_left - 1;
			end
			if (mac_rx_pa && mac_rx_word.eop) begin
				gap_left = 2;
			end
		end
	end

	always @(posedge Clk_user) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run not finished after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	//**************************************************************************
	// test sequence
	//**************************************************************************

	initial begin
		int total_words;
		int base;
		Rst_user = 1'b1;
		tx_beat  = '0;
		tx_valid = 1'b0;
		total_words = 0;
		for (int f = 0; f < N_FRAMES; f++) begin
			total_words = total_words + int'(FRAMES[f].len);
		end
		// table in both directions plus the two long tests
		cycle_limit = (2 * total_words + BP_LEN + THR_LEN) * 8 + 200;

		repeat (4) @(posedge Clk_user);
		#1;
		Rst_user = 1'b0;

		@(negedge Clk_user);
		check_bit("tx_ready", tx_ready, 1'b1);
		check_bit("mac_tx_wr", mac_tx_wr, 1'b0);
		check_bit("rx_valid", rx_valid, 1'b0);
		check_bit("mac_rx_rd", mac_rx_rd, 1'b0);
		finish_test("reset_values");

		for (int f = 0; f < N_FRAMES; f++) begin
			send_frame(int'(FRAMES[f].len), FRAMES[f].tx_keep, FRAMES[f].be, FRAMES[f].seed);
		end
		wait_tx_drain();
		finish_test("tx_encoding");

		// MAC stalled so the fifo takes exactly its depth
		wa_hold_low = 1'b1;
		repeat (2) @(negedge Clk_user);
		base = tx_accepts;
		fork
			send_frame(BP_LEN, 4'b1111, 2'b00, 32'h7600_0000);
			begin
				while (tx_accepts != base + FIFO_DEPTH) begin
					@(negedge Clk_user);
				end
				check_bit("tx_ready", tx_ready, 1'b0);
				repeat (4) @(negedge Clk_user);
				if (tx_accepts != base + FIFO_DEPTH) begin
					report_fail("tx beats accepted beyond fifo depth with mac_tx_wa low");
				end
				wa_hold_low = 1'b0;
			end
		join
		wait_tx_drain();
		finish_test("tx_backpressure");

		for (int f = 0; f < N_FRAMES; f++) begin
			load_rx_frame(int'(FRAMES[f].len), FRAMES[f].be, FRAMES[f].rx_keep,
				FRAMES[f].seed ^ 32'h00ff_0000);
		end
		wait_rx_drain();
		finish_test("rx_decoding");

		// sink stalled while the read level drops at the limit
		rx_hold_low = 1'b1;
		repeat (4) @(negedge Clk_user);
		base = rx_written;
		load_rx_frame(THR_LEN, 2'b00, 4'b1111, 32'h8700_0000);
		while (rx_written != base + RX_LIMIT) begin
			@(negedge Clk_user);
		end
		@(negedge Clk_user);
		check_bit("mac_rx_rd", mac_rx_rd, 1'b0);
		repeat (8) @(negedge Clk_user);
		check_bit("mac_rx_rd", mac_rx_rd, 1'b0);
		if (rx_written - base >= FIFO_DEPTH) begin
			report_fail("rx fifo took more words than it holds");
		end
		rx_hold_low = 1'b0;
		wait_rx_drain();
		repeat (4) @(negedge Clk_user);
		finish_test("rx_throttle");

		$display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
			err_count);
		if (err_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
